//--- files.f
+incdir+.
fix_pkg.sv
fix_tok_if.sv
fix_tokenizer.sv
fix_field_extract.sv
fix_checksum.sv
fix_parser_top.sv
fix_parser_props.sv
tb_clkgen.sv
tb_fix_parser.sv

//--- run.sh
#!/usr/bin/env bash
# builds the FIX parser testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
	-f files.f \
	--top-module tb_fix_parser

# tee keeps the pipeline going so the log decides the result
./obj_dir/Vtb_fix_parser 2>&1 | tee sim.log

if grep -q "^Simulation passed$" sim.log; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi

//--- tb_fix_parser.sv
// ################################################
// testbench for the FIX parser
// builds random messages, drives them with gaps and
// compares every reported field and checksum result
// ################################################

`timescale 1ns/1ps
`include "fix_cfg.svh"

module tb_fix_parser;
	import fix_pkg::*;

	localparam int NUM_MSGS = 10;
	localparam int TAG_W = $bits(fix_tag_t);
	localparam int VALUE_W = $bits(fix_value_t);

	logic       clk;
	logic       rst;
	logic [7:0] data_i;
	logic       valid_i;
	logic       field_valid_o;
	fix_tag_t   tag_o;
	fix_value_t value_o;
	logic       start_of_header_o;
	logic       end_of_body_o;
	logic       msg_done_o;
	logic       checksum_ok_o;

	logic [7:0]  stream[$];
	logic [7:0]  msg_q[$];
	logic [7:0]  val_q[$];
	fix_tag_t    exp_tag[$];
	fix_value_t  exp_value[$];
	logic        exp_sof[$];
	logic        exp_eob[$];
	logic        exp_ok[$];
	logic [31:0] rng;
	int          total_fields;
	int          fields_seen;
	int          msgs_seen;

	tb_clkgen #(.PERIOD_NS(4), .RESET_CYCLES(16)) i_clkgen (.clk_o(clk), .rst_o(rst));

	fix_parser_top i_dut (
		.clk               (clk),
		.rst               (rst),
		.data_i            (data_i),
		.valid_i           (valid_i),
		.field_valid_o     (field_valid_o),
		.tag_o             (tag_o),
		.value_o           (value_o),
		.start_of_header_o (start_of_header_o),
		.end_of_body_o     (end_of_body_o),
		.msg_done_o        (msg_done_o),
		.checksum_ok_o     (checksum_ok_o)
	);

	task automatic stop_on_error();
		$display("Simulation failed");
		$fatal(1, "run stopped at first error");
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] rand_below(input logic [31:0] n);
		rng = xorshift32(rng);
		return rng % n;
	endfunction

	// ################################################
	// message builder and reference model
	// ################################################

	task automatic set_value_text(input string s);
		int i;
		val_q.delete();
		for (i = 0; i < s.len(); i++) begin
			val_q.push_back(s[i]);
		end
	endtask

	task automatic random_value(input logic [31:0] len);
		val_q.delete();
		repeat (len) val_q.push_back(8'(32'h20 + rand_below(32'd95)));
	endtask

	// appends tag=value<SOH> and queues the field as the parser should report it
	task automatic push_field(input string tag);
		fix_tag_t   t;
		fix_value_t v;
		int         i;
		t = '0;
		v = '0;
		for (i = 0; i < tag.len(); i++) begin
			msg_q.push_back(tag[i]);
			t = {t[TAG_W-9:0], tag[i]};
		end
		msg_q.push_back(`FIX_EQ);
		foreach (val_q[i]) begin
			msg_q.push_back(val_q[i]);
			v = {v[VALUE_W-9:0], val_q[i]};
		end
		msg_q.push_back(`FIX_SOH);
		exp_tag.push_back(t);
		exp_value.push_back(v);
		exp_sof.push_back(tag == "8");
		exp_eob.push_back(tag == "10");
	endtask

	task automatic build_message(input logic force_long, input logic corrupt);
		logic [31:0] nfld;
		logic [31:0] tag_num;
		logic [31:0] vlen;
		logic [31:0] sum;
		logic [31:0] ck;
		int          k;
		msg_q.delete();
		set_value_text("FIX.4.4");
		push_field("8");
		nfld = 32'd2 + rand_below(32'd5);
		for (k = 0; k < int'(nfld); k++) begin
			// some fields overflow the tag and value registers
			if ((force_long && k == 0) || rand_below(32'd4) == 0) begin
				tag_num = 32'd100000 + rand_below(32'd9000000);
				vlen = 32'd33 + rand_below(32'd16);
			end else begin
				tag_num = 32'd11 + rand_below(32'd989);
				vlen = 32'd1 + rand_below(32'd12);
			end
			random_value(vlen);
			push_field($sformatf("%0d", tag_num));
		end
		// checksum covers every byte up to the SOH before tag 10
		sum = 32'd0;
		foreach (msg_q[i]) begin
			sum = sum + 32'(msg_q[i]);
		end
		if (corrupt) begin
			ck = (sum + 32'd1 + rand_below(32'd255)) % 32'd256;
		end else begin
			ck = sum % 32'd256;
		end
		set_value_text($sformatf("%03d", ck));
		push_field("10");
		exp_ok.push_back(!corrupt);
		foreach (msg_q[i]) begin
			stream.push_back(msg_q[i]);
		end
	endtask

	// ################################################
	// stimulus, monitor and watchdog
	// ################################################

	task automatic drive_byte(input logic [7:0] b);
		logic [31:0] gap;
		gap = (rand_below(32'd4) == 0) ? 32'd1 + rand_below(32'd3) : 32'd0;
		repeat (gap) begin
			@(posedge clk);
			#1;
			valid_i = 1'b0;
			data_i = 8'(rand_below(32'd256));
		end
		@(posedge clk);
		#1;
		valid_i = 1'b1;
		data_i = b;
	endtask

	task automatic run_watchdog(input logic [31:0] cycles);
		repeat (cycles) @(posedge clk);
		$display("timeout after %0d cycles, not every field was reported", cycles);
		stop_on_error();
	endtask

	task automatic check_field();
		if (exp_tag.size() == 0) begin
			$display("field reported when none was expected, tag %h", tag_o);
			stop_on_error();
		end else begin
			assert (tag_o == exp_tag[0]) else begin
				$display("MISMATCH tag_o: got %h expected %h", tag_o, exp_tag[0]);
				stop_on_error();
			end
			assert (value_o == exp_value[0]) else begin
				$display("MISMATCH value_o: got %h expected %h", value_o, exp_value[0]);
				stop_on_error();
			end
			assert (start_of_header_o == exp_sof[0]) else begin
				$display("MISMATCH start_of_header_o: got %h expected %h",
					start_of_header_o, exp_sof[0]);
				stop_on_error();
			end
			assert (end_of_body_o == exp_eob[0]) else begin
				$display("MISMATCH end_of_body_o: got %h expected %h",
					end_of_body_o, exp_eob[0]);
				stop_on_error();
			end
			void'(exp_tag.pop_front());
			void'(exp_value.pop_front());
			void'(exp_sof.pop_front());
			void'(exp_eob.pop_front());
			fields_seen++;
		end
	endtask

	task automatic check_msg();
		if (exp_ok.size() == 0) begin
			$display("msg_done_o pulsed when no message was expected");
			stop_on_error();
		end else begin
			assert (checksum_ok_o == exp_ok[0]) else begin
				$display("MISMATCH checksum_ok_o: got %h expected %h", checksum_ok_o, exp_ok[0]);
				stop_on_error();
			end
			void'(exp_ok.pop_front());
			msgs_seen++;
		end
	endtask

	// outputs are stable away from the rising edge
	always @(negedge clk) begin
		if (!rst && field_valid_o) begin
			check_field();
		end
		if (!rst && msg_done_o) begin
			check_msg();
		end
	end

	initial begin
		int          m;
		logic [31:0] limit;
		// delimiters offered while reset is held must not reach the outputs
		data_i = `FIX_SOH;
		valid_i = 1'b1;
		rng = 32'h729a;
		fields_seen = 0;
		msgs_seen = 0;
		// every third message carries a wrong checksum
		for (m = 0; m < NUM_MSGS; m++) begin
			build_message(m == 0, (m % 3) == 2);
		end
		total_fields = exp_tag.size();
		limit = 32'(stream.size()) * 32'd8 + 32'd200;
		fork
			run_watchdog(limit);
		join_none
		// stop well before the release so the first cycles after reset stay clean
		repeat (8) @(posedge clk);
		#1;
		valid_i = 1'b0;
		data_i = 8'h00;
		while (rst) begin
			@(posedge clk);
		end
		foreach (stream[i]) begin
			drive_byte(stream[i]);
		end
		@(posedge clk);
		#1;
		valid_i = 1'b0;
		while (exp_tag.size() != 0 || exp_ok.size() != 0) begin
			@(posedge clk);
		end
		repeat (4) @(posedge clk);
		if (fields_seen == total_fields && msgs_seen == NUM_MSGS) begin
			$display("Simulation passed");
			$finish;
		end else begin
			$display("wrong count: %0d fields and %0d messages seen", fields_seen, msgs_seen);
			stop_on_error();
		end
	end

endmodule

//--- tb_clkgen.sv
// ################################################
// clock and reset source for the FIX parser testbench
// reset is released 1 ns after the last reset edge
// ################################################

`timescale 1ns/1ps

module tb_clkgen #(
	parameter int PERIOD_NS = 4,
	parameter int RESET_CYCLES = 16
) (
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		forever begin
			#(PERIOD_NS / 2) clk_o = ~clk_o;
		end
	end

	initial begin
		rst_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_o);
		#1;
		rst_o = 1'b0;
	end

endmodule

//--- fix_parser_props.sv
// ################################################
// timing rules of the FIX parser outputs
// attached to fix_parser_top by the bind at the bottom
// ################################################

`timescale 1ns/1ps
`include "fix_cfg.svh"

module fix_parser_props (
	input logic       clk,
	input logic       rst,
	input logic [7:0] data_i,
	input logic       valid_i,
	input logic       field_valid_o,
	input logic       start_of_header_o,
	input logic       end_of_body_o,
	input logic       msg_done_o,
	input logic       checksum_ok_o
);

	// an SOH byte taken at the input
	logic soh_in;

	assign soh_in = valid_i && (data_i == `FIX_SOH);

	// ################################################
	// pipeline latency
	// ################################################

	field_after_soh: assert property (@(posedge clk) disable iff (rst)
		field_valid_o == $past(soh_in, 2))
		else $error("field_valid_o is not two cycles after an SOH byte");

	done_after_eob: assert property (@(posedge clk) disable iff (rst)
		end_of_body_o |=> msg_done_o)
		else $error("msg_done_o missing one cycle after end_of_body_o");

	done_needs_eob: assert property (@(posedge clk) disable iff (rst)
		msg_done_o |-> $past(end_of_body_o))
		else $error("msg_done_o without end_of_body_o one cycle before");

	// flags only ride on their strobes
	flags_on_field: assert property (@(posedge clk) disable iff (rst)
		(start_of_header_o || end_of_body_o) |-> field_valid_o)
		else $error("field flag set without field_valid_o");

	ok_on_done: assert property (@(posedge clk) disable iff (rst)
		checksum_ok_o |-> msg_done_o)
		else $error("checksum_ok_o set without msg_done_o");

	// ################################################
	// quiet during reset
	// ################################################

	quiet_in_reset: assert property (@(posedge clk)
		(rst && $past(rst)) |-> !(field_valid_o || msg_done_o || checksum_ok_o))
		else $error("output pulse while reset is held");

endmodule

bind fix_parser_top fix_parser_props i_props (.*);

//--- fix_parser_top.sv
// ################################################
// top level of the FIX parser
// takes one byte per valid_i strobe and reports fields,
// message boundaries and the checksum result as pulses
// ################################################

`timescale 1ns/1ps

module fix_parser_top (
	input  logic               clk,
	input  logic               rst,
	input  logic [7:0]         data_i,
	input  logic               valid_i,
	output logic               field_valid_o,
	output fix_pkg::fix_tag_t   tag_o,
	output fix_pkg::fix_value_t value_o,
	output logic               start_of_header_o,
	output logic               end_of_body_o,
	output logic               msg_done_o,
	output logic               checksum_ok_o
);

	fix_tok_if   tok_bus ();
	fix_field_if fld_bus ();

	// ################################################
	// parser pipeline
	// ################################################

	fix_tokenizer i_tokenizer (
		.clk     (clk),
		.rst     (rst),
		.data_i  (data_i),
		.valid_i (valid_i),
		.tok_o   (tok_bus.src)
	);

	fix_field_extract i_extract (
		.clk   (clk),
		.rst   (rst),
		.tok_i (tok_bus.snk),
		.fld_o (fld_bus.src)
	);

	fix_checksum i_checksum (
		.clk           (clk),
		.rst           (rst),
		.tok_i         (tok_bus.snk),
		.fld_i         (fld_bus.snk),
		.msg_done_o    (msg_done_o),
		.checksum_ok_o (checksum_ok_o)
	);

	// field bus straight to the pins
	assign field_valid_o = fld_bus.fld_valid;
	assign tag_o = fld_bus.fld_tag;
	assign value_o = fld_bus.fld_value;
	assign start_of_header_o = fld_bus.fld_sof;
	assign end_of_body_o = fld_bus.fld_eob;

endmodule

//--- fix_checksum.sv
// ################################################
// FIX checksum checker
// sums every tokenized byte of a message and compares the
// sum before the CheckSum field with the three digits it carries
// ################################################

`timescale 1ns/1ps

module fix_checksum (
	input  logic     clk,
	input  logic     rst,
	fix_tok_if.snk   tok_i,
	fix_field_if.snk fld_i,
	output logic     msg_done_o,
	output logic     checksum_ok_o
);
	localparam logic [7:0] ASCII_ZERO = 8'h30;
	localparam logic [7:0] ASCII_NINE = 8'h39;

	logic [7:0] run_sum;
	logic [7:0] commit_sum;
	logic [7:0] byte_add;
	logic [9:0] rx_sum;
	logic       digits_ok;
	logic       field_done;
	logic       end_of_msg;

	function automatic logic is_digit(input logic [7:0] c);
		return (c >= ASCII_ZERO) && (c <= ASCII_NINE);
	endfunction

	// the low nibble of an ASCII digit is its value
	function automatic logic [9:0] digit_val(input logic [7:0] c);
		return {6'd0, c[3:0]};
	endfunction

	// ################################################
	// received checksum, last three value bytes
	// ################################################

	assign digits_ok = is_digit(fld_i.fld_value[23:16])
		&& is_digit(fld_i.fld_value[15:8])
		&& is_digit(fld_i.fld_value[7:0]);

	assign rx_sum = digit_val(fld_i.fld_value[23:16]) * 10'd100
		+ digit_val(fld_i.fld_value[15:8]) * 10'd10
		+ digit_val(fld_i.fld_value[7:0]);

	// ################################################
	// running and committed sums
	// ################################################

	assign byte_add = tok_i.tok_valid ? tok_i.tok_byte : 8'h00;
	assign field_done = fld_i.fld_valid && !fld_i.fld_eob;
	assign end_of_msg = fld_i.fld_valid && fld_i.fld_eob;

	always_ff @(posedge clk) begin
		if (rst) begin
			run_sum <= 8'h00;
			commit_sum <= 8'h00;
			msg_done_o <= 1'b0;
			checksum_ok_o <= 1'b0;
		end else begin
			if (end_of_msg) begin
				// a byte of the next message may already be on the bus
				run_sum <= byte_add;
				commit_sum <= 8'h00;
			end else begin
				run_sum <= run_sum + byte_add;
				if (field_done) begin
					commit_sum <= run_sum;
				end
			end
			msg_done_o <= end_of_msg;
			checksum_ok_o <= end_of_msg && digits_ok && (rx_sum == {2'b00, commit_sum});
		end
	end

endmodule

//--- fix_field_extract.sv
// ################################################
// field extractor of the FIX parser
// collects tag and value bytes from the token bus and
// emits one field per SOH, flagging BeginString and CheckSum
// ################################################

`timescale 1ns/1ps
`include "fix_cfg.svh"

module fix_field_extract (
	input  logic    clk,
	input  logic    rst,
	fix_tok_if.snk  tok_i,
	fix_field_if.src fld_o
);
	import fix_pkg::*;

	localparam int TAG_W = `FIX_TAG_BYTES * 8;
	localparam int VALUE_W = `FIX_VALUE_BYTES * 8;

	fix_tag_t   tag_q;
	fix_value_t value_q;

	logic tok_tag;
	logic tok_value;
	logic tok_soh;
	logic is_begin;
	logic is_checksum;

	assign tok_tag = tok_i.tok_valid && (tok_i.tok_class == CLS_TAG);
	assign tok_value = tok_i.tok_valid && (tok_i.tok_class == CLS_VALUE);
	assign tok_soh = tok_i.tok_valid && (tok_i.tok_class == CLS_SOH);

	// ################################################
	// tag and value shift registers
	// ################################################

	// new bytes enter at the bottom, the oldest fall off the top
	always_ff @(posedge clk) begin
		if (tok_tag) begin
			if (tok_i.tok_first) begin
				tag_q <= fix_tag_t'(tok_i.tok_byte);
			end else begin
				tag_q <= {tag_q[TAG_W-9:0], tok_i.tok_byte};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (tok_value) begin
			if (tok_i.tok_first) begin
				value_q <= fix_value_t'(tok_i.tok_byte);
			end else begin
				value_q <= {value_q[VALUE_W-9:0], tok_i.tok_byte};
			end
		end
	end

	// ################################################
	// field output
	// ################################################

	assign is_begin = (tag_q == TAG_BEGIN_STRING);
	assign is_checksum = (tag_q == TAG_CHECKSUM);

	// flags are pulses that line up with fld_valid
	always_ff @(posedge clk) begin
		if (rst) begin
			fld_o.fld_valid <= 1'b0;
			fld_o.fld_sof <= 1'b0;
			fld_o.fld_eob <= 1'b0;
		end else begin
			fld_o.fld_valid <= tok_soh;
			fld_o.fld_sof <= tok_soh && is_begin;
			fld_o.fld_eob <= tok_soh && is_checksum;
		end
	end

	always_ff @(posedge clk) begin
		if (tok_soh) begin
			fld_o.fld_tag <= tag_q;
			fld_o.fld_value <= value_q;
		end
	end

endmodule

//--- fix_tokenizer.sv
// ################################################
// byte classifier at the front of the FIX parser
// labels each input byte as tag, value or delimiter
// and presents it on the token bus one cycle later
// ################################################

`timescale 1ns/1ps
`include "fix_cfg.svh"

module fix_tokenizer (
	input  logic       clk,
	input  logic       rst,
	input  logic [7:0] data_i,
	input  logic       valid_i,
	fix_tok_if.src     tok_o
);
	import fix_pkg::*;

	// set between '=' and SOH
	logic       in_value;
	// previous byte closed a tag or a value
	logic       after_delim;
	fix_class_e byte_class;
	logic       is_data;

	// ################################################
	// classification
	// ################################################

	always_comb begin
		if (data_i == `FIX_SOH) begin
			byte_class = CLS_SOH;
		end else if (data_i == `FIX_EQ && !in_value) begin
			byte_class = CLS_EQ;
		end else if (in_value) begin
			// a second '=' inside a value is plain data
			byte_class = CLS_VALUE;
		end else begin
			byte_class = CLS_TAG;
		end
	end

	assign is_data = (byte_class == CLS_TAG) || (byte_class == CLS_VALUE);

	always_ff @(posedge clk) begin
		if (rst) begin
			in_value <= 1'b0;
			after_delim <= 1'b1;
		end else if (valid_i) begin
			in_value <= (byte_class == CLS_EQ) || (in_value && byte_class != CLS_SOH);
			after_delim <= !is_data;
		end
	end

	// ################################################
	// token register
	// ################################################

	always_ff @(posedge clk) begin
		if (rst) begin
			tok_o.tok_valid <= 1'b0;
		end else begin
			tok_o.tok_valid <= valid_i;
		end
	end

	always_ff @(posedge clk) begin
		if (valid_i) begin
			tok_o.tok_byte <= data_i;
			tok_o.tok_class <= byte_class;
			tok_o.tok_first <= after_delim && is_data;
		end
	end

endmodule

//--- fix_tok_if.sv
// ################################################
// buses between the parser blocks
// fix_tok_if carries classified bytes, fix_field_if finished fields
// ################################################

`timescale 1ns/1ps

interface fix_tok_if;
	import fix_pkg::*;

	logic       tok_valid;
	logic [7:0] tok_byte;
	fix_class_e tok_class;
	logic       tok_first;

	modport src (output tok_valid, output tok_byte, output tok_class, output tok_first);
	modport snk (input tok_valid, input tok_byte, input tok_class, input tok_first);
endinterface

interface fix_field_if;
	import fix_pkg::*;

	logic       fld_valid;
	fix_tag_t   fld_tag;
	fix_value_t fld_value;
	logic       fld_sof;
	logic       fld_eob;

	modport src (output fld_valid, output fld_tag, output fld_value, output fld_sof, output fld_eob);
	modport snk (input fld_valid, input fld_tag, input fld_value, input fld_sof, input fld_eob);
endinterface

//--- fix_pkg.sv
// ################################################
// shared types for the FIX parser and its testbench
// compile before any file that imports it
// ################################################

`include "fix_cfg.svh"

package fix_pkg;

	// ################################################
	// field payload types
	// ################################################

	// tag digits in ASCII, right-aligned
	typedef logic [`FIX_TAG_BYTES*8-1:0] fix_tag_t;

	// value bytes in ASCII, right-aligned
	typedef logic [`FIX_VALUE_BYTES*8-1:0] fix_value_t;

	// ################################################
	// byte classes from the tokenizer
	// ################################################

	typedef enum logic [1:0] {
		CLS_TAG,
		CLS_VALUE,
		CLS_EQ,
		CLS_SOH
	} fix_class_e;

	// BeginString opens a message, CheckSum closes it
	localparam fix_tag_t TAG_BEGIN_STRING = fix_tag_t'(8'h38);
	localparam fix_tag_t TAG_CHECKSUM = fix_tag_t'(16'h3130);

endpackage

//--- fix_cfg.svh
// ################################################
// build-time sizes and delimiter bytes for the FIX parser
// include this wherever a width or delimiter is needed
// ################################################

`ifndef FIX_CFG_SVH
`define FIX_CFG_SVH

// number of tag digits held, oldest dropped first
`define FIX_TAG_BYTES 4

// number of value bytes held, oldest dropped first
`define FIX_VALUE_BYTES 32

// field delimiter and tag/value separator
`define FIX_SOH 8'h01
`define FIX_EQ 8'h3d

`endif
